//--- design/wg_budget_check.sv
////////////////////////////////////////////////////////////////////////////
// Write guard budget selection per slot phase and timeout detection
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "wg_defs.svh"

module wg_budget_check (
  input  wg_pkg::wg_phase_e     phase_i [`WG_SLOTS],
  input  logic [`WG_CNT_W-1:0]  count_i [`WG_SLOTS],
  input  logic [`WG_LEN_W-1:0]  len_i   [`WG_SLOTS],
  input  logic [`WG_CNT_W-1:0]  budget_aw_i,
  input  logic [`WG_CNT_W-1:0]  budget_wfirst_i,
  input  logic [`WG_CNT_W-1:0]  budget_wunit_i,
  input  logic [`WG_CNT_W-1:0]  budget_b_i,
  output logic                  fault_o,
  output logic [`WG_SLOT_W-1:0] fault_slot_o,
  output wg_pkg::wg_cause_e     fault_cause_o
);
  import wg_pkg::*;

  // Room for the unit budget times sixteen beats
  logic [`WG_CNT_W+`WG_LEN_W:0] limit [`WG_SLOTS];
  wg_cause_e                    cause [`WG_SLOTS];
  logic [`WG_SLOTS-1:0]         over;

  always_comb begin
    for (int i = 0; i < `WG_SLOTS; i++) begin
      limit[i] = '0;
      cause[i] = NONE;
      case (phase_i[i])
        AW_HS: begin
          limit[i] = {{(`WG_LEN_W + 1){1'b0}}, budget_aw_i};
          cause[i] = AW_TIMEOUT;
        end
        W_WAIT: begin
          limit[i] = {{(`WG_LEN_W + 1){1'b0}}, budget_wfirst_i};
          cause[i] = W_FIRST_TIMEOUT;
        end
        // Burst of len+1 beats gets one unit per beat
        W_BURST: begin
          limit[i] = budget_wunit_i * ({1'b0, len_i[i]} + 1'b1);
          cause[i] = W_BURST_TIMEOUT;
        end
        B_WAIT: begin
          limit[i] = {{(`WG_LEN_W + 1){1'b0}}, budget_b_i};
          cause[i] = B_TIMEOUT;
        end
        default: begin
          limit[i] = '0;
          cause[i] = NONE;
        end
      endcase
      over[i] = (cause[i] != NONE) && ({{(`WG_LEN_W + 1){1'b0}}, count_i[i]} > limit[i]);
    end
  end

  // Lowest faulty slot is reported
  always_comb begin
    fault_o       = |over;
    fault_slot_o  = '0;
    fault_cause_o = NONE;
    for (int i = `WG_SLOTS - 1; i >= 0; i--) begin
      if (over[i]) begin
        fault_slot_o  = `WG_SLOT_W'(i);
        fault_cause_o = cause[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/wg_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Write guard fault arbitration and log capture, tracking flush,
// interrupt and the four-phase reset request handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "wg_defs.svh"

module wg_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fault_i,
  input  logic [`WG_SLOT_W-1:0] fault_slot_i,
  input  wg_pkg::wg_cause_e     fault_cause_i,
  input  logic                  unwanted_i,
  input  logic                  overflow_i,
  input  logic [`WG_ID_W-1:0]   b_id_i,
  input  logic [3:0]            b_pending_i,
  input  logic [`WG_ID_W-1:0]   aw_id_i,
  input  logic [`WG_ADDR_W-1:0] aw_addr_i,
  input  logic [`WG_ID_W-1:0]   id_i   [`WG_SLOTS],
  input  logic [`WG_ADDR_W-1:0] addr_i [`WG_SLOTS],
  input  logic                  reset_ack_i,
  output logic                  flush_o,
  output logic                  irq_o,
  output logic                  reset_req_o,
  output wg_pkg::wg_cause_e     log_cause_o,
  output wg_pkg::wg_log_u       log_word_o
);
  import wg_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK_LOW
  } state_e;

  state_e    state_q;
  state_e    state_d;
  logic      any_fault;
  wg_cause_e cause_sel;
  wg_log_u   word_sel;

  assign any_fault = fault_i | unwanted_i | overflow_i;

  // Timeouts first, then unwanted responses, then overflow
  always_comb begin
    cause_sel = NONE;
    word_sel  = '0;
    if (fault_i) begin
      cause_sel         = fault_cause_i;
      word_sel.txn.id   = id_i[fault_slot_i];
      word_sel.txn.addr = addr_i[fault_slot_i];
    end else if (unwanted_i) begin
      cause_sel            = UNWANTED_B;
      word_sel.unw.b_id    = b_id_i;
      word_sel.unw.pending = b_pending_i;
    end else if (overflow_i) begin
      cause_sel         = OVERFLOW;
      word_sel.txn.id   = aw_id_i;
      word_sel.txn.addr = aw_addr_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:         if (any_fault) state_d = REQ;
      REQ:          if (reset_ack_i) state_d = WAIT_ACK_LOW;
      WAIT_ACK_LOW: if (!reset_ack_i) state_d = IDLE;
      default:      state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      log_cause_o <= NONE;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && any_fault) begin
        log_cause_o <= cause_sel;
      end
    end
  end

  // Only the first fault is kept until the handshake ends
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && any_fault) begin
      log_word_o <= word_sel;
    end
  end

  // Outputs decode straight from the state register
  assign reset_req_o = (state_q == REQ);
  assign irq_o       = (state_q != IDLE);
  assign flush_o     = (state_q != IDLE);

endmodule

`default_nettype wire

//--- design/wg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Write guard types for slot phases, fault causes and the log word
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "wg_defs.svh"

package wg_pkg;

  // Life cycle of one tracked write transaction
  typedef enum logic [2:0] {
    FREE,
    AW_HS,
    W_WAIT,
    W_BURST,
    B_WAIT
  } wg_phase_e;

  typedef enum logic [2:0] {
    NONE            = `WG_CAUSE_NONE,
    AW_TIMEOUT      = `WG_CAUSE_AW_TIMEOUT,
    W_FIRST_TIMEOUT = `WG_CAUSE_W_FIRST_TIMEOUT,
    W_BURST_TIMEOUT = `WG_CAUSE_W_BURST_TIMEOUT,
    B_TIMEOUT       = `WG_CAUSE_B_TIMEOUT,
    UNWANTED_B      = `WG_CAUSE_UNWANTED_B,
    OVERFLOW        = `WG_CAUSE_OVERFLOW
  } wg_cause_e;

  // Record of the transaction that timed out or overflowed
  typedef struct packed {
    logic [`WG_ID_W-1:0]   id;
    logic [`WG_ADDR_W-1:0] addr;
    logic [3:0]            rsvd;
  } wg_txn_log_t;

  // Record of a response nobody was waiting for
  typedef struct packed {
    logic [`WG_ID_W-1:0] b_id;
    logic [3:0]          pending;
    logic [15:0]         rsvd;
  } wg_unw_log_t;

  // Log_cause_o tells which view applies
  typedef union packed {
    wg_txn_log_t txn;
    wg_unw_log_t unw;
  } wg_log_u;

endpackage

`default_nettype wire

//--- design/wg_slot_table.sv
////////////////////////////////////////////////////////////////////////////
// Write guard slot table with allocation, phase tracking per slot,
// phase cycle counters and response matching
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "wg_defs.svh"

module wg_slot_table (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  // Observed address channel
  input  logic                  aw_valid_i,
  input  logic                  aw_ready_i,
  input  logic [`WG_ID_W-1:0]   aw_id_i,
  input  logic [`WG_ADDR_W-1:0] aw_addr_i,
  input  logic [`WG_LEN_W-1:0]  aw_len_i,
  // Observed data and response channels
  input  logic                  w_valid_i,
  input  logic                  w_ready_i,
  input  logic                  w_last_i,
  input  logic                  b_valid_i,
  input  logic                  b_ready_i,
  input  logic [`WG_ID_W-1:0]   b_id_i,
  // Slot whose write data is due next
  input  logic [`WG_SLOT_W-1:0] fifo_head_i,
  output wg_pkg::wg_phase_e     phase_o [`WG_SLOTS],
  output logic [`WG_CNT_W-1:0]  count_o [`WG_SLOTS],
  output logic [`WG_LEN_W-1:0]  len_o   [`WG_SLOTS],
  output logic [`WG_ID_W-1:0]   id_o    [`WG_SLOTS],
  output logic [`WG_ADDR_W-1:0] addr_o  [`WG_SLOTS],
  output logic                  aw_push_o,
  output logic [`WG_SLOT_W-1:0] aw_slot_o,
  output logic                  w_pop_o,
  output logic                  unwanted_o,
  output logic                  overflow_o,
  output logic [3:0]            b_pending_o
);
  import wg_pkg::*;

  wg_phase_e             phase_q [`WG_SLOTS];
  wg_phase_e             phase_d [`WG_SLOTS];
  logic [`WG_CNT_W-1:0]  cnt_q   [`WG_SLOTS];
  logic [`WG_LEN_W-1:0]  len_q   [`WG_SLOTS];
  logic [`WG_ID_W-1:0]   id_q    [`WG_SLOTS];
  logic [`WG_ADDR_W-1:0] addr_q  [`WG_SLOTS];

  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic                  aw_hs_any;
  logic [`WG_SLOT_W-1:0] aw_hs_idx;
  logic                  free_any;
  logic [`WG_SLOT_W-1:0] free_idx;
  logic                  b_match_any;
  logic [`WG_SLOT_W-1:0] b_match_idx;
  logic                  head_active;
  logic                  alloc_en;

  assign aw_hs = aw_valid_i & aw_ready_i;
  assign w_hs  = w_valid_i & w_ready_i;
  assign b_hs  = b_valid_i & b_ready_i;

  // Scan from the top so that the lowest matching index wins
  always_comb begin
    aw_hs_any   = 1'b0;
    aw_hs_idx   = '0;
    free_any    = 1'b0;
    free_idx    = '0;
    b_match_any = 1'b0;
    b_match_idx = '0;
    b_pending_o = '0;
    for (int i = `WG_SLOTS - 1; i >= 0; i--) begin
      if (phase_q[i] == AW_HS) begin
        aw_hs_any = 1'b1;
        aw_hs_idx = `WG_SLOT_W'(i);
      end
      if (phase_q[i] == FREE) begin
        free_any = 1'b1;
        free_idx = `WG_SLOT_W'(i);
      end
      if (phase_q[i] == B_WAIT && id_q[i] == b_id_i) begin
        b_match_any = 1'b1;
        b_match_idx = `WG_SLOT_W'(i);
      end
      if (phase_q[i] == B_WAIT) begin
        b_pending_o = b_pending_o + 4'd1;
      end
    end
  end

  // At most one slot waits for its address handshake
  assign alloc_en = aw_valid_i & ~aw_hs_any & free_any;

  // Head of the order queue only counts while it expects data
  assign head_active = (phase_q[fifo_head_i] == W_WAIT) ||
                       (phase_q[fifo_head_i] == W_BURST);

  assign aw_push_o  = aw_hs & (aw_hs_any | free_any);
  assign aw_slot_o  = aw_hs_any ? aw_hs_idx : free_idx;
  assign w_pop_o    = w_hs & w_last_i & head_active;
  assign overflow_o = aw_hs & ~aw_hs_any & ~free_any;
  assign unwanted_o = b_hs & ~b_match_any;

  always_comb begin
    phase_d = phase_q;
    // A handshake on the very first valid cycle skips AW_HS
    if (alloc_en) begin
      phase_d[free_idx] = aw_hs ? W_WAIT : AW_HS;
    end else if (aw_hs && aw_hs_any) begin
      phase_d[aw_hs_idx] = W_WAIT;
    end
    if (w_hs && head_active) begin
      phase_d[fifo_head_i] = w_last_i ? B_WAIT : W_BURST;
    end
    if (b_hs && b_match_any) begin
      phase_d[b_match_idx] = FREE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WG_SLOTS; i++) begin
        phase_q[i] <= FREE;
        cnt_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < `WG_SLOTS; i++) begin
        if (flush_i) begin
          phase_q[i] <= FREE;
          cnt_q[i]   <= '0;
        end else begin
          phase_q[i] <= phase_d[i];
          // Restart on each phase change, saturate at the top
          if (phase_d[i] != phase_q[i]) begin
            cnt_q[i] <= '0;
          end else if (phase_q[i] != FREE && cnt_q[i] != '1) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
          end
        end
      end
    end
  end

  // Transaction attributes captured when the slot is taken
  always_ff @(posedge clk_i) begin
    if (alloc_en) begin
      id_q[free_idx]   <= aw_id_i;
      addr_q[free_idx] <= aw_addr_i;
      len_q[free_idx]  <= aw_len_i;
    end
  end

  assign phase_o = phase_q;
  assign count_o = cnt_q;
  assign len_o   = len_q;
  assign id_o    = id_q;
  assign addr_o  = addr_q;

endmodule

`default_nettype wire

//--- design/wg_w_order_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Write guard order queue of slot indices awaiting write data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "wg_defs.svh"

module wg_w_order_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  logic [`WG_SLOT_W-1:0] push_slot_i,
  input  logic                  pop_i,
  output logic [`WG_SLOT_W-1:0] head_o,
  output logic                  empty_o
);

  logic [`WG_SLOT_W-1:0] mem_q [`WG_SLOTS];
  // Extra top bit tells a full queue from an empty one
  logic [`WG_SLOT_W:0]   wr_ptr_q;
  logic [`WG_SLOT_W:0]   rd_ptr_q;
  logic                  full;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full    = (wr_ptr_q[`WG_SLOT_W-1:0] == rd_ptr_q[`WG_SLOT_W-1:0]) &&
                   (wr_ptr_q[`WG_SLOT_W] != rd_ptr_q[`WG_SLOT_W]);
  assign head_o  = mem_q[rd_ptr_q[`WG_SLOT_W-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i && !full) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i && !empty_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !full && !flush_i) begin
      mem_q[wr_ptr_q[`WG_SLOT_W-1:0]] <= push_slot_i;
    end
  end

endmodule

`default_nettype wire

//--- design/write_guard.sv
////////////////////////////////////////////////////////////////////////////
// Write guard top level, a passive AXI write channel timing monitor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "wg_defs.svh"

module write_guard (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Observed write bus
  input  logic                  aw_valid_i,
  input  logic                  aw_ready_i,
  input  logic [`WG_ID_W-1:0]   aw_id_i,
  input  logic [`WG_ADDR_W-1:0] aw_addr_i,
  input  logic [`WG_LEN_W-1:0]  aw_len_i,
  input  logic                  w_valid_i,
  input  logic                  w_ready_i,
  input  logic                  w_last_i,
  input  logic                  b_valid_i,
  input  logic                  b_ready_i,
  input  logic [`WG_ID_W-1:0]   b_id_i,
  // Static phase budgets in cycles
  input  logic [`WG_CNT_W-1:0]  budget_aw_i,
  input  logic [`WG_CNT_W-1:0]  budget_wfirst_i,
  input  logic [`WG_CNT_W-1:0]  budget_wunit_i,
  input  logic [`WG_CNT_W-1:0]  budget_b_i,
  // Fault reporting and reset handshake
  output logic                  irq_o,
  output logic                  reset_req_o,
  input  logic                  reset_ack_i,
  output wg_pkg::wg_cause_e     log_cause_o,
  output wg_pkg::wg_log_u       log_word_o
);
  import wg_pkg::*;

  wg_phase_e             phase   [`WG_SLOTS];
  logic [`WG_CNT_W-1:0]  count   [`WG_SLOTS];
  logic [`WG_LEN_W-1:0]  len     [`WG_SLOTS];
  logic [`WG_ID_W-1:0]   slot_id [`WG_SLOTS];
  logic [`WG_ADDR_W-1:0] slot_addr [`WG_SLOTS];
  logic                  flush;
  logic                  aw_push;
  logic [`WG_SLOT_W-1:0] aw_slot;
  logic                  w_pop;
  logic [`WG_SLOT_W-1:0] fifo_head;
  logic                  unwanted;
  logic                  overflow;
  logic [3:0]            b_pending;
  logic                  fault;
  logic [`WG_SLOT_W-1:0] fault_slot;
  wg_cause_e             fault_cause;

  wg_slot_table slot_table_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_i  (aw_ready_i),
    .aw_id_i     (aw_id_i),
    .aw_addr_i   (aw_addr_i),
    .aw_len_i    (aw_len_i),
    .w_valid_i   (w_valid_i),
    .w_ready_i   (w_ready_i),
    .w_last_i    (w_last_i),
    .b_valid_i   (b_valid_i),
    .b_ready_i   (b_ready_i),
    .b_id_i      (b_id_i),
    .fifo_head_i (fifo_head),
    .phase_o     (phase),
    .count_o     (count),
    .len_o       (len),
    .id_o        (slot_id),
    .addr_o      (slot_addr),
    .aw_push_o   (aw_push),
    .aw_slot_o   (aw_slot),
    .w_pop_o     (w_pop),
    .unwanted_o  (unwanted),
    .overflow_o  (overflow),
    .b_pending_o (b_pending)
  );

  // Empty flag is guarded inside the queue itself
  wg_w_order_fifo w_order_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .push_i      (aw_push),
    .push_slot_i (aw_slot),
    .pop_i       (w_pop),
    .head_o      (fifo_head),
    .empty_o     ()
  );

  wg_budget_check budget_check_i (
    .phase_i         (phase),
    .count_i         (count),
    .len_i           (len),
    .budget_aw_i     (budget_aw_i),
    .budget_wfirst_i (budget_wfirst_i),
    .budget_wunit_i  (budget_wunit_i),
    .budget_b_i      (budget_b_i),
    .fault_o         (fault),
    .fault_slot_o    (fault_slot),
    .fault_cause_o   (fault_cause)
  );

  wg_ctrl ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fault_i       (fault),
    .fault_slot_i  (fault_slot),
    .fault_cause_i (fault_cause),
    .unwanted_i    (unwanted),
    .overflow_i    (overflow),
    .b_id_i        (b_id_i),
    .b_pending_i   (b_pending),
    .aw_id_i       (aw_id_i),
    .aw_addr_i     (aw_addr_i),
    .id_i          (slot_id),
    .addr_i        (slot_addr),
    .reset_ack_i   (reset_ack_i),
    .flush_o       (flush),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .log_cause_o   (log_cause_o),
    .log_word_o    (log_word_o)
  );

endmodule

`default_nettype wire

//--- include/wg_defs.svh
////////////////////////////////////////////////////////////////////////////
// Write guard sizes, widths and fault cause encodings
////////////////////////////////////////////////////////////////////////////
`ifndef WG_DEFS_SVH
`define WG_DEFS_SVH

// Observed bus field widths
`define WG_ID_W   4
`define WG_ADDR_W 16
`define WG_LEN_W  4

// Phase counters and budgets share one width
`define WG_CNT_W  12

// Tracked transactions and the index width that addresses them
`define WG_SLOTS  4
`define WG_SLOT_W 2

// Fault causes as reported on log_cause_o
`define WG_CAUSE_NONE            3'd0
`define WG_CAUSE_AW_TIMEOUT      3'd1
`define WG_CAUSE_W_FIRST_TIMEOUT 3'd2
`define WG_CAUSE_W_BURST_TIMEOUT 3'd3
`define WG_CAUSE_B_TIMEOUT       3'd4
`define WG_CAUSE_UNWANTED_B      3'd5
`define WG_CAUSE_OVERFLOW        3'd6

`endif

//--- verif/tb_write_guard.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the write guard with a file driven write bus model,
// log checks, reset handshake responder and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "wg_defs.svh"

module tb_write_guard;
  import wg_pkg::*;

  localparam int CLK_HALF   = 2;
  localparam int CLK_PERIOD = 2 * CLK_HALF;
  localparam int DRIVE_DLY  = 1;
  localparam int RST_CYCLES = 16;
  localparam int MAX_SCEN   = 32;
  localparam int MAX_TXN    = 5;
  localparam int SETTLE     = 8;
  localparam int HS_LIMIT   = 32;
  localparam int BUDGET_AW  = 16;
  localparam int BUDGET_WF  = 64;
  localparam int BUDGET_WU  = 4;
  localparam int BUDGET_B   = 64;
  // Room for settling, the reset handshake and the slowest timeout
  localparam int EST_MARGIN = 2 * BUDGET_B + 64;

  // Header columns of one data line
  localparam int F_N     = 0;
  localparam int F_AWD   = 1;
  localparam int F_WFD   = 2;
  localparam int F_GAP   = 3;
  localparam int F_BD    = 4;
  localparam int F_BMODE = 5;
  localparam int F_BID   = 6;
  localparam int F_HOLD  = 7;
  localparam int F_CAUSE = 8;
  localparam int F_E1    = 9;
  localparam int F_E2    = 10;

  logic                  clk;
  logic                  rst_n;
  logic                  aw_valid;
  logic                  aw_ready;
  logic [`WG_ID_W-1:0]   aw_id;
  logic [`WG_ADDR_W-1:0] aw_addr;
  logic [`WG_LEN_W-1:0]  aw_len;
  logic                  w_valid;
  logic                  w_ready;
  logic                  w_last;
  logic                  b_valid;
  logic                  b_ready;
  logic [`WG_ID_W-1:0]   b_id;
  logic [`WG_CNT_W-1:0]  budget_aw;
  logic [`WG_CNT_W-1:0]  budget_wfirst;
  logic [`WG_CNT_W-1:0]  budget_wunit;
  logic [`WG_CNT_W-1:0]  budget_b;
  logic                  irq;
  logic                  reset_req;
  logic                  reset_ack;
  wg_cause_e             log_cause;
  wg_log_u               log_word;

  int          hdr      [MAX_SCEN][11];
  int          txn_id   [MAX_SCEN][MAX_TXN];
  int          txn_addr [MAX_SCEN][MAX_TXN];
  int          txn_len  [MAX_SCEN][MAX_TXN];
  int          num_scen;
  int          max_len;
  int          wd_cycles;
  int          checks;
  int          value_errors;
  int          other_errors;
  int unsigned seed;
  // Set once irq_o has been seen during the current scenario
  logic        halted;

  write_guard dut_i (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .aw_valid_i      (aw_valid),
    .aw_ready_i      (aw_ready),
    .aw_id_i         (aw_id),
    .aw_addr_i       (aw_addr),
    .aw_len_i        (aw_len),
    .w_valid_i       (w_valid),
    .w_ready_i       (w_ready),
    .w_last_i        (w_last),
    .b_valid_i       (b_valid),
    .b_ready_i       (b_ready),
    .b_id_i          (b_id),
    .budget_aw_i     (budget_aw),
    .budget_wfirst_i (budget_wfirst),
    .budget_wunit_i  (budget_wunit),
    .budget_b_i      (budget_b),
    .irq_o           (irq),
    .reset_req_o     (reset_req),
    .reset_ack_i     (reset_ack),
    .log_cause_o     (log_cause),
    .log_word_o      (log_word)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_HALF) clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks = checks + 1;
    if (actual !== expected) begin
      value_errors = value_errors + 1;
      $display("error: time %0t signal %s got %0h expected %0h",
               $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string msg);
    other_errors = other_errors + 1;
    $display("failure at time %0t: %s", $time, msg);
  endtask

  // Inputs change a short delay after the rising edge
  task automatic tick();
    @(posedge clk);
    #(DRIVE_DLY);
    if (irq) begin
      halted = 1'b1;
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n && !halted; i++) begin
      tick();
    end
  endtask

  task automatic idle_bus();
    aw_valid = 1'b0;
    aw_ready = 1'b0;
    w_valid  = 1'b0;
    w_ready  = 1'b0;
    w_last   = 1'b0;
    b_valid  = 1'b0;
    b_ready  = 1'b0;
  endtask

  // Addresses first, then bursts in order, then responses
  task automatic drive_scenario(input int s);
    int n;
    int beat;
    int resp;
    n = hdr[s][F_N];
    for (int k = 0; k < n && !halted; k++) begin
      aw_valid = 1'b1;
      aw_ready = 1'b0;
      aw_id    = txn_id[s][k];
      aw_addr  = txn_addr[s][k];
      aw_len   = txn_len[s][k];
      wait_cycles(hdr[s][F_AWD]);
      if (!halted) begin
        aw_ready = 1'b1;
        tick();
      end
      idle_bus();
    end
    for (int k = 0; k < n && !halted; k++) begin
      wait_cycles(hdr[s][F_WFD]);
      beat = 0;
      // A held burst keeps beating without last until the guard trips
      while (!halted && (beat <= txn_len[s][k] || hdr[s][F_HOLD] != 0)) begin
        w_valid = 1'b1;
        w_ready = 1'b1;
        w_last  = (beat == txn_len[s][k]) && (hdr[s][F_HOLD] == 0);
        tick();
        idle_bus();
        wait_cycles(hdr[s][F_GAP]);
        beat++;
      end
    end
    resp = (hdr[s][F_BMODE] != 0) ? 1 : n;
    for (int k = 0; k < resp && !halted; k++) begin
      wait_cycles(hdr[s][F_BD]);
      if (!halted) begin
        b_valid = 1'b1;
        b_ready = 1'b1;
        b_id    = (hdr[s][F_BMODE] != 0) ? hdr[s][F_BID] : txn_id[s][k];
        tick();
      end
      idle_bus();
    end
  endtask

  // Four-phase acknowledge of the reset request
  task automatic ack_reset();
    int cnt;
    repeat (1 + ($urandom % 8)) begin
      tick();
    end
    check_value("reset_req_o", reset_req, 1);
    reset_ack = 1'b1;
    cnt = 0;
    while (reset_req && cnt < HS_LIMIT) begin
      tick();
      cnt++;
    end
    if (reset_req) begin
      report_failure("reset_req_o stayed high although reset_ack_i was raised");
    end
    check_value("irq_o", irq, 1);
    repeat (1 + ($urandom % 4)) begin
      tick();
    end
    check_value("reset_req_o", reset_req, 0);
    reset_ack = 1'b0;
    cnt = 0;
    while (irq && cnt < HS_LIMIT) begin
      tick();
      cnt++;
    end
    if (irq) begin
      report_failure("irq_o stayed high after reset_ack_i returned low");
    end
    halted = 1'b0;
  endtask

  task automatic run_scenario(input int s);
    int cnt;
    int cause;
    cause  = hdr[s][F_CAUSE];
    halted = 1'b0;
    drive_scenario(s);
    idle_bus();
    cnt = 0;
    while (!halted && cnt < SETTLE) begin
      tick();
      cnt++;
    end
    if (cause == `WG_CAUSE_NONE) begin
      if (halted) begin
        report_failure($sformatf("scenario %0d raised irq_o on clean traffic", s));
      end
    end else if (!halted) begin
      report_failure($sformatf("scenario %0d never raised irq_o for its fault", s));
    end else begin
      check_value("reset_req_o", reset_req, 1);
      check_value("log_cause_o", log_cause, cause);
      if (cause == `WG_CAUSE_UNWANTED_B) begin
        check_value("log_word_o.unw.b_id", log_word.unw.b_id, hdr[s][F_E1]);
        check_value("log_word_o.unw.pending", log_word.unw.pending, hdr[s][F_E2]);
      end else begin
        check_value("log_word_o.txn.id", log_word.txn.id, hdr[s][F_E1]);
        check_value("log_word_o.txn.addr", log_word.txn.addr, hdr[s][F_E2]);
      end
    end
    if (halted) begin
      ack_reset();
    end
  endtask

  initial begin
    wait (wd_cycles > 0);
    #(wd_cycles * CLK_PERIOD * 2);
    $display("failure: watchdog expired before all scenarios finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int    fd;
    int    code;
    int    got;
    int    est;
    string line;
    int    h [11];
    int    t [15];
    seed          = 32'h1a7ef8c6;
    void'($urandom(seed));
    rst_n         = 1'b0;
    reset_ack     = 1'b0;
    aw_id         = '0;
    aw_addr       = '0;
    aw_len        = '0;
    b_id          = '0;
    budget_aw     = BUDGET_AW;
    budget_wfirst = BUDGET_WF;
    budget_wunit  = BUDGET_WU;
    budget_b      = BUDGET_B;
    idle_bus();
    halted        = 1'b0;
    checks        = 0;
    value_errors  = 0;
    other_errors  = 0;
    num_scen      = 0;
    max_len       = EST_MARGIN;
    wd_cycles     = 0;

    fd = $fopen("verif/wg_input.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the scenario file verif/wg_input.txt");
    end else begin
      while (!$feof(fd) && num_scen < MAX_SCEN) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%d%d%d%d%d%d%h%d%d%h%h%h%h%d%h%h%d%h%h%d%h%h%d%h%h%d",
                        h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7], h[8], h[9],
                        h[10], t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8],
                        t[9], t[10], t[11], t[12], t[13], t[14]);
          if (got != 26) begin
            report_failure("scenario file holds a line with missing columns");
          end else begin
            for (int j = 0; j < 11; j++) begin
              hdr[num_scen][j] = h[j];
            end
            est = EST_MARGIN + h[F_N] * (h[F_AWD] + h[F_WFD] + h[F_BD] + 2);
            for (int k = 0; k < MAX_TXN; k++) begin
              txn_id[num_scen][k]   = t[3 * k];
              txn_addr[num_scen][k] = t[3 * k + 1];
              txn_len[num_scen][k]  = t[3 * k + 2];
              est = est + (t[3 * k + 2] + 1) * (h[F_GAP] + 1);
            end
            if (est > max_len) begin
              max_len = est;
            end
            num_scen++;
          end
        end
      end
      $fclose(fd);
    end
    wd_cycles = (num_scen + 1) * max_len + RST_CYCLES;

    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    tick();
    check_value("irq_o", irq, 0);
    check_value("reset_req_o", reset_req, 0);
    check_value("log_cause_o", log_cause, `WG_CAUSE_NONE);

    if (num_scen == 0) begin
      report_failure("no scenarios were read from the scenario file");
    end
    for (int s = 0; s < num_scen; s++) begin
      run_scenario(s);
    end

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/wg_input.txt
# n aw_dly w_dly gap b_dly b_mode b_id hold cause exp1 exp2, then id addr len for 5 txns
# b_id, id, addr, exp1, exp2 in hex; cause 0 none 1 aw 3 burst 4 b 5 unwanted 6 overflow
3 2  2 1 3   0 0 0 0 0 0     1 1000 1  2 2040 3  3 30c0 0  0 0000 0  0 0000 0
4 1  1 0 2   0 0 0 0 0 0     2 2100 0  2 2200 1  3 3300 0  1 1400 2  0 0000 0
1 1  3 1 4   0 0 0 0 0 0     4 4000 7  0 0000 0  0 0000 0  0 0000 0  0 0000 0
1 1  3 1 4   0 0 1 3 5 5010  5 5010 0  0 0000 0  0 0000 0  0 0000 0  0 0000 0
1 0  2 1 2   0 0 0 0 0 0     3 3a00 2  0 0000 0  0 0000 0  0 0000 0  0 0000 0
1 40 2 1 2   0 0 0 1 6 6200  6 6200 2  0 0000 0  0 0000 0  0 0000 0  0 0000 0
2 1  2 1 2   0 0 0 0 0 0     6 6300 1  7 6400 0  0 0000 0  0 0000 0  0 0000 0
1 1  2 1 140 0 0 0 4 7 7f00  7 7f00 1  0 0000 0  0 0000 0  0 0000 0  0 0000 0
1 2  1 0 3   0 0 0 0 0 0     7 7f40 3  0 0000 0  0 0000 0  0 0000 0  0 0000 0
2 0  1 0 2   1 c 0 5 c 2     8 8000 0  9 9000 1  0 0000 0  0 0000 0  0 0000 0
2 1  1 1 1   0 0 0 0 0 0     8 8100 2  9 9100 0  0 0000 0  0 0000 0  0 0000 0
5 1  2 1 2   0 0 0 6 e e000  a a000 0  b b000 0  c c000 0  d d000 0  e e000 0
2 2  2 1 2   0 0 0 0 0 0     f f000 3  0 0010 1  0 0000 0  0 0000 0  0 0000 0

//--- verif/write_guard_sva.sv
////////////////////////////////////////////////////////////////////////////
// Bound checks on the write guard reset request handshake, the
// interrupt and the log word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module write_guard_sva (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            irq_i,
  input logic            reset_req_i,
  input logic            reset_ack_i,
  input wg_pkg::wg_log_u log_word_i
);

  // Interrupt and request are low once reset is released
  a_reset_quiet: assert property (@(posedge clk_i) $rose(rst_ni) |-> !irq_i && !reset_req_i)
    else $error("irq or reset request high after reset");

  // New request only while the previous acknowledge is gone
  a_req_rise_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(reset_req_i) |-> !reset_ack_i)
    else $error("reset request rose while acknowledge was high");

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reset_req_i && !reset_ack_i |=> reset_req_i)
    else $error("reset request dropped before acknowledge");

  // Log holds the first fault for the whole interrupt
  a_log_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_i && $past(irq_i) |-> $stable(log_word_i))
    else $error("log word changed while interrupt was high");

endmodule

bind write_guard write_guard_sva sva_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .irq_i       (irq_o),
  .reset_req_i (reset_req_o),
  .reset_ack_i (reset_ack_i),
  .log_word_i  (log_word_o)
);

`default_nettype wire

//--- verilog.f
+incdir+include
design/wg_pkg.sv
design/wg_slot_table.sv
design/wg_w_order_fifo.sv
design/wg_budget_check.sv
design/wg_ctrl.sv
design/write_guard.sv
verif/write_guard_sva.sv
verif/tb_write_guard.sv
